//--- flist.f
verilog/exe_pkg.sv
verilog/exe_decode.sv
verilog/exe_forward.sv
verilog/exe_alu.sv
verilog/exe_branch.sv
verilog/exe_result.sv
verilog/exe_top.sv
verif/tb_clkgen.sv
verif/tb_exe.sv

//--- Bender.yml
package:
  name: exe_stage

sources:
  - files:
      - verilog/exe_pkg.sv
      - verilog/exe_decode.sv
      - verilog/exe_forward.sv
      - verilog/exe_alu.sv
      - verilog/exe_branch.sv
      - verilog/exe_result.sv
      - verilog/exe_top.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/tb_exe.sv

//--- verif/tb_exe.sv
`default_nettype none

module tb_exe;
    timeunit 1ns;
    timeprecision 100ps;

    // expected state of the two pipeline stages
    typedef struct packed {
        exe_pkg::wb_t     mid0;
        exe_pkg::wb_t     mid1;
        exe_pkg::wb_t     wb0;
        exe_pkg::wb_t     wb1;
        exe_pkg::br_res_t branch;
        logic             flush;
    } model_t;

    logic               clk;
    logic               rst_n;
    logic               flush_by_writeback;
    exe_pkg::lane_uop_t lane0_uop;
    exe_pkg::lane_uop_t lane1_uop;
    exe_pkg::word_t     rf_data00;
    exe_pkg::word_t     rf_data01;
    exe_pkg::word_t     rf_data10;
    exe_pkg::word_t     rf_data11;
    exe_pkg::wb_t       wb0;
    exe_pkg::wb_t       wb1;
    exe_pkg::br_res_t   branch;
    logic               flush;

    exe_pkg::word_t     rf [32];
    model_t             m;
    logic [31:0]        lfsr;
    int                 errors;
    int                 checks;

    tb_clkgen u_clkgen (.clk, .rst_n);

    exe_top UUT (
        .clk, .rst_n, .flush_by_writeback, .lane0_uop, .lane1_uop,
        .rf_data00, .rf_data01, .rf_data10, .rf_data11, .wb0, .wb1, .branch, .flush
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic exe_pkg::lane_uop_t make_uop(exe_pkg::exe_op_e op, int rd, int rj,
                                                   int rk, exe_pkg::word_t imm, logic src2_imm);
        exe_pkg::lane_uop_t u;
        u          = '0;
        u.valid    = 1'b1;
        u.op       = op;
        u.rd       = 5'(rd);
        u.rj       = 5'(rj);
        u.rk       = 5'(rk);
        u.imm      = imm;
        u.src2_imm = src2_imm;
        u.pc       = 32'h1c00_0100;
        u.pc_next  = u.pc + 32'd4;
        return u;
    endfunction

    function automatic exe_pkg::lane_uop_t random_uop();
        exe_pkg::lane_uop_t u;
        u          = '0;
        u.valid    = (rand_bits(3) != 0);
        u.op       = exe_pkg::exe_op_e'(5'(rand_bits(5) % 22));
        u.rd       = 5'(rand_bits(3));
        u.rj       = 5'(rand_bits(3));
        u.rk       = 5'(rand_bits(3));
        u.src2_imm = 1'(rand_bits(1));
        u.imm      = rand_bits(1) ? rand_bits(32) : {20'h0, 10'(rand_bits(10)), 2'b00};
        u.pc       = {14'h0700, 16'(rand_bits(16)), 2'b00};
        u.pc_next  = u.pc + 32'd4;
        return u;
    endfunction

    // newest in-flight result wins and r0 reads as zero
    function automatic exe_pkg::word_t operand(exe_pkg::reg_addr_t r, model_t s);
        if (r == '0) return '0;
        if (s.mid1.en && s.mid1.rd == r) return s.mid1.data;
        if (s.mid0.en && s.mid0.rd == r) return s.mid0.data;
        if (s.wb1.en && s.wb1.rd == r) return s.wb1.data;
        if (s.wb0.en && s.wb0.rd == r) return s.wb0.data;
        return rf[r];
    endfunction

    function automatic exe_pkg::wb_t lane_alu(exe_pkg::lane_uop_t u, model_t s);
        exe_pkg::wb_t   w;
        exe_pkg::word_t a;
        exe_pkg::word_t b;
        w = '0;
        a = operand(u.rj, s);
        b = (u.src2_imm || u.op == exe_pkg::op_lu12i) ? u.imm : operand(u.rk, s);
        if (u.valid && u.op <= exe_pkg::op_lu12i && u.rd != '0) begin
            w.en = 1'b1;
            w.rd = u.rd;
            case (u.op)
                exe_pkg::op_add:  w.data = a + b;
                exe_pkg::op_sub:  w.data = a - b;
                exe_pkg::op_slt:  w.data = {31'b0, $signed(a) < $signed(b)};
                exe_pkg::op_sltu: w.data = {31'b0, a < b};
                exe_pkg::op_and:  w.data = a & b;
                exe_pkg::op_or:   w.data = a | b;
                exe_pkg::op_xor:  w.data = a ^ b;
                exe_pkg::op_nor:  w.data = ~(a | b);
                exe_pkg::op_sll:  w.data = a << b[4:0];
                exe_pkg::op_srl:  w.data = a >> b[4:0];
                exe_pkg::op_sra:  w.data = $signed(a) >>> b[4:0];
                default:          w.data = u.imm;
            endcase
        end
        return w;
    endfunction

    function automatic exe_pkg::br_res_t branch_ref(exe_pkg::lane_uop_t u, exe_pkg::word_t a,
                                                    exe_pkg::word_t b);
        exe_pkg::br_res_t r;
        exe_pkg::word_t   target;
        r      = '0;
        target = ((u.op == exe_pkg::op_jirl) ? a : u.pc) + u.imm;
        case (u.op)
            exe_pkg::op_beq:  r.taken = (a == b);
            exe_pkg::op_bne:  r.taken = (a != b);
            exe_pkg::op_blt:  r.taken = ($signed(a) < $signed(b));
            exe_pkg::op_bge:  r.taken = ($signed(a) >= $signed(b));
            exe_pkg::op_bltu: r.taken = (a < b);
            exe_pkg::op_bgeu: r.taken = (a >= b);
            default:          r.taken = 1'b1;
        endcase
        r.valid        = 1'b1;
        r.pc           = u.pc;
        r.correct_next = r.taken ? target : u.pc + 32'd4;
        r.mispredict   = (r.correct_next != u.pc_next);
        return r;
    endfunction

    // expected stage contents after one rising edge
    function automatic model_t ref_step(model_t s, exe_pkg::lane_uop_t l0,
                                        exe_pkg::lane_uop_t l1, logic fbw);
        model_t           n;
        exe_pkg::wb_t     w0;
        exe_pkg::wb_t     w1;
        exe_pkg::br_res_t br;
        w0 = lane_alu(l0, s);
        w1 = lane_alu(l1, s);
        br = '0;
        if (l0.valid && l0.op >= exe_pkg::op_jirl && l0.op <= exe_pkg::op_bgeu) begin
            br = branch_ref(l0, operand(l0.rj, s), operand(l0.rk, s));
            if (l0.op == exe_pkg::op_bl || (l0.op == exe_pkg::op_jirl && l0.rd != '0)) begin
                w0.en   = 1'b1;
                w0.rd   = (l0.op == exe_pkg::op_bl) ? 5'd1 : l0.rd;
                w0.data = l0.pc + 32'd4;
            end
        end
        n     = '0;
        n.wb0 = fbw ? '0 : s.mid0;
        n.wb1 = fbw ? '0 : s.mid1;
        if (!(fbw || s.flush)) begin
            n.mid0   = w0;
            n.mid1   = br.mispredict ? '0 : w1;
            n.branch = br;
            n.flush  = br.mispredict;
        end
        return n;
    endfunction

    // pred 1 predicts the branch correctly, 2 wrongly, 0 leaves pc_next alone
    task automatic issue(exe_pkg::lane_uop_t l0, exe_pkg::lane_uop_t l1, logic fbw, int pred);
        exe_pkg::wb_t     old0;
        exe_pkg::wb_t     old1;
        exe_pkg::br_res_t br;
        @(posedge clk);
        old0 = m.wb0;
        old1 = m.wb1;
        m    = ref_step(m, lane0_uop, lane1_uop, flush_by_writeback);
        if (old0.en) rf[old0.rd] = old0.data;
        if (old1.en) rf[old1.rd] = old1.data;
        if (pred != 0) begin
            br = branch_ref(l0, operand(l0.rj, m), operand(l0.rk, m));
            l0.pc_next = (pred == 1) ? br.correct_next : br.correct_next + 32'd8;
        end
        lane0_uop          <= l0;
        lane1_uop          <= l1;
        flush_by_writeback <= fbw;
        rf_data00          <= rf[l0.rj];
        rf_data01          <= rf[l0.rk];
        rf_data10          <= rf[l1.rj];
        rf_data11          <= rf[l1.rk];
    endtask

    task automatic issue_nop();
        issue(make_uop(exe_pkg::op_nop, 0, 0, 0, '0, 1'b0),
              make_uop(exe_pkg::op_nop, 0, 0, 0, '0, 1'b0), 1'b0, 0);
    endtask

    task automatic wait_flush();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < 4 && !seen; i++) begin
            @(negedge clk);
            if (flush === 1'b1) begin
                seen = 1'b1;
            end else begin
                issue_nop();
            end
        end
        if (!seen) begin
            errors++;
            $display("no flush pulse after a mispredicted branch");
        end
    endtask

    task automatic compare(string name, logic [66:0] got, logic [66:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    always @(negedge clk) begin
        compare("wb0", 67'(wb0), 67'(m.wb0));
        compare("wb1", 67'(wb1), 67'(m.wb1));
        compare("branch", 67'(branch), 67'(m.branch));
        compare("flush", 67'(flush), 67'(m.flush));
    end

    initial begin
        exe_pkg::lane_uop_t l0;
        exe_pkg::lane_uop_t l1;
        exe_pkg::reg_addr_t dest;
        m                  = '0;
        errors             = 0;
        checks             = 0;
        lfsr               = 32'hb780_c397;
        flush_by_writeback = 1'b0;
        lane0_uop          = '0;
        lane1_uop          = '0;
        rf_data00          = '0;
        rf_data01          = '0;
        rf_data10          = '0;
        rf_data11          = '0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = (i == 0) ? '0 : rand_bits(32);
        end
        for (int i = 0; i < 10 && rst_n !== 1'b1; i++) begin
            @(posedge clk);
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("reset was never released");
        end

        // every ALU function on both lanes and then r0 destinations
        for (int op = 0; op < 12; op++) begin
            issue(make_uop(exe_pkg::exe_op_e'(5'(op)), 2, 3, 4, 32'h0000_0123, 1'b0),
                  make_uop(exe_pkg::exe_op_e'(5'(op)), 5, 6, 7, 32'h0000_0045, 1'b0), 1'b0, 0);
        end
        issue(make_uop(exe_pkg::op_add, 0, 3, 4, '0, 1'b0),
              make_uop(exe_pkg::op_or, 0, 6, 7, '0, 1'b0), 1'b0, 0);

        // dependent chain through both stages with both lanes writing r12
        for (int i = 0; i < 4; i++) begin
            issue(make_uop(exe_pkg::op_add, 9, 10, 9, '0, 1'b0),
                  make_uop(exe_pkg::op_sub, 10, 10, 11, '0, 1'b0), 1'b0, 0);
            issue(make_uop(exe_pkg::op_xor, 11, 9, 10, '0, 1'b0),
                  make_uop(exe_pkg::op_add, 9, 10, 12, '0, 1'b0), 1'b0, 0);
            issue(make_uop(exe_pkg::op_or, 12, 9, 11, '0, 1'b0),
                  make_uop(exe_pkg::op_and, 12, 10, 9, '0, 1'b0), 1'b0, 0);
        end

        // each branch kind with equal operands and both unequal orders
        for (int op = 12; op < 21; op++) begin
            issue(make_uop(exe_pkg::exe_op_e'(5'(op)), 13, 3, 3, 32'h40, 1'b0),
                  make_uop(exe_pkg::op_add, 14, 5, 6, '0, 1'b0), 1'b0, 1);
            issue(make_uop(exe_pkg::exe_op_e'(5'(op)), 13, 3, 4, 32'hffff_ffc0, 1'b0),
                  make_uop(exe_pkg::op_sub, 14, 6, 5, '0, 1'b0), 1'b0, 1);
            issue(make_uop(exe_pkg::exe_op_e'(5'(op)), 13, 4, 3, 32'h40, 1'b0),
                  make_uop(exe_pkg::op_add, 14, 6, 5, '0, 1'b0), 1'b0, 1);
        end

        // mispredicts squash lane 1 and the following pair
        issue(make_uop(exe_pkg::op_beq, 0, 3, 3, 32'h80, 1'b0),
              make_uop(exe_pkg::op_add, 15, 5, 6, '0, 1'b0), 1'b0, 2);
        issue(make_uop(exe_pkg::op_add, 16, 5, 6, '0, 1'b0),
              make_uop(exe_pkg::op_sub, 17, 6, 5, '0, 1'b0), 1'b0, 0);
        wait_flush();
        issue(make_uop(exe_pkg::op_jirl, 18, 9, 0, 32'h10, 1'b0),
              make_uop(exe_pkg::op_or, 19, 5, 6, '0, 1'b0), 1'b0, 2);
        issue(make_uop(exe_pkg::op_xor, 16, 5, 6, '0, 1'b0),
              make_uop(exe_pkg::op_nor, 17, 6, 5, '0, 1'b0), 1'b0, 0);
        wait_flush();

        // writeback flush with two pairs in flight
        issue(make_uop(exe_pkg::op_add, 20, 3, 4, '0, 1'b0),
              make_uop(exe_pkg::op_add, 21, 5, 6, '0, 1'b0), 1'b0, 0);
        issue(make_uop(exe_pkg::op_sub, 22, 20, 4, '0, 1'b0),
              make_uop(exe_pkg::op_sub, 23, 21, 6, '0, 1'b0), 1'b0, 0);
        issue(make_uop(exe_pkg::op_or, 20, 22, 23, '0, 1'b0),
              make_uop(exe_pkg::op_and, 21, 22, 23, '0, 1'b0), 1'b1, 0);

        for (int i = 0; i < 400; i++) begin
            l0   = random_uop();
            l1   = random_uop();
            dest = (l0.op == exe_pkg::op_bl) ? 5'd1 : l0.rd;
            // lane 1 never reads lane 0's destination of the same pair
            if (l1.rj == dest) l1.rj = l1.rj ^ 5'd8;
            if (l1.rk == dest) l1.rk = l1.rk ^ 5'd8;
            issue(l0, l1, (rand_bits(5) == 0), int'(rand_bits(2) % 3));
        end

        repeat (3) issue_nop();
        @(negedge clk);
        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // low for three cycles, released away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/exe_top.sv
`default_nettype none

module exe_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               flush_by_writeback,
    input  wire exe_pkg::lane_uop_t lane0_uop,
    input  wire exe_pkg::lane_uop_t lane1_uop,
    input  wire exe_pkg::word_t     rf_data00,
    input  wire exe_pkg::word_t     rf_data01,
    input  wire exe_pkg::word_t     rf_data10,
    input  wire exe_pkg::word_t     rf_data11,
    output exe_pkg::wb_t            wb0,
    output exe_pkg::wb_t            wb1,
    output exe_pkg::br_res_t        branch,
    output logic                    flush
);

    logic               lane0_alu_en;
    logic               lane1_alu_en;
    logic               lane0_br_en;
    logic               lane0_src2_imm;
    logic               lane1_src2_imm;
    exe_pkg::alu_op_e   lane0_alu_op;
    exe_pkg::alu_op_e   lane1_alu_op;
    exe_pkg::br_op_e    br_op;
    exe_pkg::reg_addr_t lane0_wb_rd;
    exe_pkg::reg_addr_t lane1_wb_rd;
    exe_pkg::word_t     lane0_src0;
    exe_pkg::word_t     lane0_src1;
    exe_pkg::word_t     lane1_src0;
    exe_pkg::word_t     lane1_src1;
    exe_pkg::word_t     lane0_alu_src1;
    exe_pkg::word_t     lane1_alu_src1;
    exe_pkg::wb_t       alu0_res;
    exe_pkg::wb_t       alu1_res;
    exe_pkg::wb_t       link_res;
    exe_pkg::br_res_t   br_res;
    exe_pkg::wb_t       mid0;
    exe_pkg::wb_t       mid1;

    exe_decode u_decode (
        .lane0_uop, .lane1_uop, .lane0_alu_en, .lane1_alu_en, .lane0_br_en,
        .lane0_src2_imm, .lane1_src2_imm, .lane0_alu_op, .lane1_alu_op,
        .br_op, .lane0_wb_rd, .lane1_wb_rd
    );

    exe_forward u_forward (
        .lane0_uop, .lane1_uop, .rf_data00, .rf_data01, .rf_data10, .rf_data11,
        .mid0, .mid1, .out0(wb0), .out1(wb1),
        .lane0_src0, .lane0_src1, .lane1_src0, .lane1_src1
    );

    // second operand select
    assign lane0_alu_src1 = lane0_src2_imm ? lane0_uop.imm : lane0_src1;
    assign lane1_alu_src1 = lane1_src2_imm ? lane1_uop.imm : lane1_src1;

    exe_alu u_alu0 (
        .en(lane0_alu_en), .alu_op(lane0_alu_op), .src0(lane0_src0),
        .src1(lane0_alu_src1), .rd(lane0_wb_rd), .result(alu0_res)
    );

    exe_alu u_alu1 (
        .en(lane1_alu_en), .alu_op(lane1_alu_op), .src0(lane1_src0),
        .src1(lane1_alu_src1), .rd(lane1_wb_rd), .result(alu1_res)
    );

    exe_branch u_branch (
        .en(lane0_br_en), .br_op, .uop(lane0_uop), .src0(lane0_src0),
        .src1(lane0_src1), .wb_rd(lane0_wb_rd), .link(link_res), .res(br_res)
    );

    exe_result u_result (
        .clk, .rst_n, .flush_by_writeback, .alu0(alu0_res), .alu1(alu1_res),
        .link(link_res), .br_in(br_res), .mid0, .mid1, .wb0, .wb1, .branch, .flush
    );

endmodule

`default_nettype wire

//--- verilog/exe_result.sv
`default_nettype none

module exe_result (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             flush_by_writeback,
    input  wire exe_pkg::wb_t     alu0,
    input  wire exe_pkg::wb_t     alu1,
    input  wire exe_pkg::wb_t     link,
    input  wire exe_pkg::br_res_t br_in,
    output exe_pkg::wb_t          mid0,
    output exe_pkg::wb_t          mid1,
    output exe_pkg::wb_t          wb0,
    output exe_pkg::wb_t          wb1,
    output exe_pkg::br_res_t      branch,
    output logic                  flush
);

    exe_pkg::wb_t lane0_next;
    logic         squash_pair;
    logic         squash_lane1;

    // only one of alu0 and link is ever nonzero
    assign lane0_next = alu0 | link;

    // previous pair mispredicted or writeback flush
    assign squash_pair  = flush_by_writeback || flush;
    assign squash_lane1 = squash_pair || br_in.mispredict;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid0   <= '0;
            mid1   <= '0;
            branch <= '0;
            flush  <= 1'b0;
        end else begin
            mid0   <= squash_pair ? '0 : lane0_next;
            mid1   <= squash_lane1 ? '0 : alu1;
            branch <= squash_pair ? '0 : br_in;
            flush  <= !squash_pair && br_in.mispredict;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb0 <= '0;
            wb1 <= '0;
        end else if (flush_by_writeback) begin
            wb0 <= '0;
            wb1 <= '0;
        end else begin
            wb0 <= mid0;
            wb1 <= mid1;
        end
    end

    lane0_single_source: assert property (
        @(posedge clk) disable iff (!rst_n) !(alu0.en && link.en)
    ) else $error("lane 0 ALU and link results enabled together");

    no_r0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
            !(lane0_next.en && lane0_next.rd == '0) && !(alu1.en && alu1.rd == '0)
    ) else $error("result for r0 entering the mid stage");

endmodule

`default_nettype wire

//--- verilog/exe_branch.sv
`default_nettype none

module exe_branch (
    input  wire logic               en,
    input  wire exe_pkg::br_op_e    br_op,
    input  wire exe_pkg::lane_uop_t uop,
    input  wire exe_pkg::word_t     src0,
    input  wire exe_pkg::word_t     src1,
    input  wire exe_pkg::reg_addr_t wb_rd,
    output exe_pkg::wb_t            link,
    output exe_pkg::br_res_t        res
);

    exe_pkg::word_t target;
    exe_pkg::word_t pc_plus4;
    exe_pkg::word_t correct_next;
    logic           taken;

    // jirl is register relative, the rest pc relative
    assign target   = ((br_op == exe_pkg::br_jirl) ? src0 : uop.pc) + uop.imm;
    assign pc_plus4 = uop.pc + 32'd4;

    always_comb begin
        case (br_op)
            exe_pkg::br_jirl,
            exe_pkg::br_b,
            exe_pkg::br_bl:   taken = 1'b1;
            exe_pkg::br_beq:  taken = (src0 == src1);
            exe_pkg::br_bne:  taken = (src0 != src1);
            exe_pkg::br_blt:  taken = ($signed(src0) < $signed(src1));
            exe_pkg::br_bge:  taken = ($signed(src0) >= $signed(src1));
            exe_pkg::br_bltu: taken = (src0 < src1);
            exe_pkg::br_bgeu: taken = (src0 >= src1);
            default:          taken = 1'b0;
        endcase
    end

    assign correct_next = taken ? target : pc_plus4;

    always_comb begin
        res = '0;
        if (en) begin
            res.valid        = 1'b1;
            res.taken        = taken;
            res.mispredict   = (correct_next != uop.pc_next);
            res.pc           = uop.pc;
            res.correct_next = correct_next;
        end
    end

    // link write for jirl and bl, wb_rd already r1 for bl
    always_comb begin
        link = '0;
        if (en && (br_op == exe_pkg::br_jirl || br_op == exe_pkg::br_bl)
                && wb_rd != '0) begin
            link.en   = 1'b1;
            link.rd   = wb_rd;
            link.data = pc_plus4;
        end
    end

endmodule

`default_nettype wire

//--- verilog/exe_alu.sv
`default_nettype none

module exe_alu (
    input  wire logic               en,
    input  wire exe_pkg::alu_op_e   alu_op,
    input  wire exe_pkg::word_t     src0,
    input  wire exe_pkg::word_t     src1,
    input  wire exe_pkg::reg_addr_t rd,
    output exe_pkg::wb_t            result
);

    exe_pkg::word_t value;
    logic [4:0]     shamt;

    assign shamt = src1[4:0];

    always_comb begin
        case (alu_op)
            exe_pkg::alu_add:   value = src0 + src1;
            exe_pkg::alu_sub:   value = src0 - src1;
            exe_pkg::alu_slt:   value = {31'b0, $signed(src0) < $signed(src1)};
            exe_pkg::alu_sltu:  value = {31'b0, src0 < src1};
            exe_pkg::alu_and:   value = src0 & src1;
            exe_pkg::alu_or:    value = src0 | src1;
            exe_pkg::alu_xor:   value = src0 ^ src1;
            exe_pkg::alu_nor:   value = ~(src0 | src1);
            exe_pkg::alu_sll:   value = src0 << shamt;
            exe_pkg::alu_srl:   value = src0 >> shamt;
            exe_pkg::alu_sra:   value = $signed(src0) >>> shamt;
            // immediate arrives already shifted
            exe_pkg::alu_lu12i: value = src1;
            default:            value = '0;
        endcase
    end

    // zero when idle so lane 0 can OR with the link result
    always_comb begin
        result = '0;
        if (en) begin
            result.en   = 1'b1;
            result.rd   = rd;
            result.data = value;
        end
    end

endmodule

`default_nettype wire

//--- verilog/exe_forward.sv
`default_nettype none

module exe_forward (
    input  wire exe_pkg::lane_uop_t lane0_uop,
    input  wire exe_pkg::lane_uop_t lane1_uop,
    input  wire exe_pkg::word_t     rf_data00,
    input  wire exe_pkg::word_t     rf_data01,
    input  wire exe_pkg::word_t     rf_data10,
    input  wire exe_pkg::word_t     rf_data11,
    input  wire exe_pkg::wb_t       mid0,
    input  wire exe_pkg::wb_t       mid1,
    input  wire exe_pkg::wb_t       out0,
    input  wire exe_pkg::wb_t       out1,
    output exe_pkg::word_t          lane0_src0,
    output exe_pkg::word_t          lane0_src1,
    output exe_pkg::word_t          lane1_src0,
    output exe_pkg::word_t          lane1_src1
);

    // index 0 is the newest entry
    exe_pkg::wb_t [3:0] inflight;

    assign inflight = {out0, out1, mid0, mid1};

    function automatic exe_pkg::word_t pick(
        exe_pkg::reg_addr_t src,
        exe_pkg::word_t     rf,
        exe_pkg::wb_t [3:0] cand
    );
        exe_pkg::word_t value;
        value = rf;
        // oldest first so newer matches overwrite
        for (int i = 3; i >= 0; i--) begin
            if (cand[i].en && cand[i].rd == src) begin
                value = cand[i].data;
            end
        end
        if (src == '0) begin
            value = '0;
        end
        return value;
    endfunction

    assign lane0_src0 = pick(lane0_uop.rj, rf_data00, inflight);
    assign lane0_src1 = pick(lane0_uop.rk, rf_data01, inflight);
    assign lane1_src0 = pick(lane1_uop.rj, rf_data10, inflight);
    assign lane1_src1 = pick(lane1_uop.rk, rf_data11, inflight);

endmodule

`default_nettype wire

//--- verilog/exe_decode.sv
`default_nettype none

module exe_decode (
    input  wire exe_pkg::lane_uop_t lane0_uop,
    input  wire exe_pkg::lane_uop_t lane1_uop,
    output logic                    lane0_alu_en,
    output logic                    lane1_alu_en,
    output logic                    lane0_br_en,
    output logic                    lane0_src2_imm,
    output logic                    lane1_src2_imm,
    output exe_pkg::alu_op_e        lane0_alu_op,
    output exe_pkg::alu_op_e        lane1_alu_op,
    output exe_pkg::br_op_e         br_op,
    output exe_pkg::reg_addr_t      lane0_wb_rd,
    output exe_pkg::reg_addr_t      lane1_wb_rd
);

    // ALU codes share their order with the first twelve micro-ops
    function automatic logic is_alu(exe_pkg::exe_op_e op);
        return op <= exe_pkg::op_lu12i;
    endfunction

    function automatic exe_pkg::alu_op_e alu_of(exe_pkg::exe_op_e op);
        return exe_pkg::alu_op_e'(op[3:0]);
    endfunction

    function automatic exe_pkg::br_op_e br_of(exe_pkg::exe_op_e op);
        case (op)
            exe_pkg::op_jirl: return exe_pkg::br_jirl;
            exe_pkg::op_b:    return exe_pkg::br_b;
            exe_pkg::op_bl:   return exe_pkg::br_bl;
            exe_pkg::op_beq:  return exe_pkg::br_beq;
            exe_pkg::op_bne:  return exe_pkg::br_bne;
            exe_pkg::op_blt:  return exe_pkg::br_blt;
            exe_pkg::op_bge:  return exe_pkg::br_bge;
            exe_pkg::op_bltu: return exe_pkg::br_bltu;
            exe_pkg::op_bgeu: return exe_pkg::br_bgeu;
            default:          return exe_pkg::br_none;
        endcase
    endfunction

    logic lane0_alu_valid;
    logic lane1_alu_valid;

    assign lane0_alu_valid = lane0_uop.valid && is_alu(lane0_uop.op);
    assign lane1_alu_valid = lane1_uop.valid && is_alu(lane1_uop.op);

    // r0 writes are dropped here
    assign lane0_alu_en   = lane0_alu_valid && (lane0_uop.rd != '0);
    assign lane1_alu_en   = lane1_alu_valid && (lane1_uop.rd != '0);
    assign lane0_alu_op   = alu_of(lane0_uop.op);
    assign lane1_alu_op   = alu_of(lane1_uop.op);
    assign lane0_src2_imm = lane0_uop.src2_imm || (lane0_uop.op == exe_pkg::op_lu12i);
    assign lane1_src2_imm = lane1_uop.src2_imm || (lane1_uop.op == exe_pkg::op_lu12i);

    // branches only on lane 0
    assign br_op       = lane0_uop.valid ? br_of(lane0_uop.op) : exe_pkg::br_none;
    assign lane0_br_en = (br_op != exe_pkg::br_none);

    always_comb begin
        lane0_wb_rd = '0;
        if (lane0_alu_valid || br_op == exe_pkg::br_jirl) begin
            lane0_wb_rd = lane0_uop.rd;
        end else if (br_op == exe_pkg::br_bl) begin
            lane0_wb_rd = 5'd1;
        end
    end

    assign lane1_wb_rd = lane1_alu_valid ? lane1_uop.rd : '0;

endmodule

`default_nettype wire

//--- verilog/exe_pkg.sv
`default_nettype none

package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // issued micro-op codes, ALU ops first
    typedef enum logic [4:0] {
        op_add, op_sub, op_slt, op_sltu,
        op_and, op_or, op_xor, op_nor,
        op_sll, op_srl, op_sra, op_lu12i,
        op_jirl, op_b, op_bl, op_beq, op_bne,
        op_blt, op_bge, op_bltu, op_bgeu,
        op_nop
    } exe_op_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra, alu_lu12i
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none, br_jirl, br_b, br_bl,
        br_beq, br_bne, br_blt, br_bge,
        br_bltu, br_bgeu
    } br_op_e;

    // one issued instruction
    typedef struct packed {
        logic      valid;
        exe_op_e   op;
        logic      src2_imm;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        word_t     imm;
        word_t     pc;
        // predicted next pc
        word_t     pc_next;
    } lane_uop_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic  valid;
        logic  taken;
        logic  mispredict;
        word_t pc;
        word_t correct_next;
    } br_res_t;

endpackage

`default_nettype wire
